//--- ahbArb.f
src/ahbArbPkg.sv
src/ahbArbiterController.sv
src/ahbWaitMemory.sv
src/ahbArbTop.sv
bench/ahbArb_assert.sv
bench/ahbArbBench.sv

//--- bench/ahbArbBench.sv
`timescale 1ns/1ps

module ahbArbBench;

    // One transfer set with mask bits {T, M, F}
    // Grant order packs three codes with the first in the top bits
    // Codes are T=1 M=2 F=3
    typedef struct packed {
        logic [2:0]                      mask;
        logic [ahbArbPkg::addrWidth-1:0] addrT;
        logic [ahbArbPkg::addrWidth-1:0] addrM;
        logic [ahbArbPkg::addrWidth-1:0] addrF;
        logic                            writeM;
        ahbArbPkg::hSize                 sizeM;
        logic [ahbArbPkg::dataWidth-1:0] wdataM;
        logic [5:0]                      order;
    } stimRow;

    logic                            clk;
    logic                            reset;
    logic                            HRequestT;
    logic                            HRequestM;
    logic                            HRequestF;
    logic [ahbArbPkg::addrWidth-1:0] HAddrT;
    logic [ahbArbPkg::addrWidth-1:0] HAddrM;
    logic [ahbArbPkg::addrWidth-1:0] HAddrF;
    logic                            HWriteM;
    ahbArbPkg::hSize                 HSizeM;
    logic [ahbArbPkg::dataWidth-1:0] HWDataM;
    logic                            HReadyT;
    logic                            HReadyM;
    logic                            HReadyF;
    logic [ahbArbPkg::dataWidth-1:0] HRData;

    // Expected memory contents
    logic [ahbArbPkg::dataWidth-1:0] shadow [ahbArbPkg::memWords];

    stimRow rows[$];
    int     randomRows = 40;
    int     timeoutLimit;
    int     cycleCount = 0;

    ahbArbTop dut (
        .clk       (clk),
        .reset     (reset),
        .HRequestT (HRequestT),
        .HAddrT    (HAddrT),
        .HReadyT   (HReadyT),
        .HRequestM (HRequestM),
        .HAddrM    (HAddrM),
        .HWriteM   (HWriteM),
        .HSizeM    (HSizeM),
        .HWDataM   (HWDataM),
        .HReadyM   (HReadyM),
        .HRequestF (HRequestF),
        .HAddrF    (HAddrF),
        .HReadyF   (HReadyF),
        .HRData    (HRData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit scales with the number of rows
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            $display("Timeout: transfers not finished within %0d cycles", timeoutLimit);
            $display("Test failed");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got,
                     expected);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] byteAddr(input int wordIndex, input int byteOffset);
        return 32'(wordIndex * 4 + byteOffset);
    endfunction

    // Wait states come straight from the address
    function automatic int waitOf(input logic [31:0] addr);
        logic [1:0] w;
        w = addr[ahbArbPkg::waitLsb +: 2];
        return int'(w);
    endfunction

    function automatic logic [1:0] orderAt(input logic [5:0] order, input int pos);
        return order[5 - 2 * pos -: 2];
    endfunction

    function automatic logic [1:0] codeOf(input logic [2:0] readies);
        case (readies)
            3'b100:  return 2'd1;
            3'b010:  return 2'd2;
            3'b001:  return 2'd3;
            default: return 2'd0;
        endcase
    endfunction

    function automatic logic [31:0] addrOf(input stimRow row, input logic [1:0] code);
        case (code)
            2'd1:    return row.addrT;
            2'd2:    return row.addrM;
            default: return row.addrF;
        endcase
    endfunction

    // Priority T, M, F for every mask
    function automatic logic [5:0] expectedOrder(input logic [2:0] mask);
        logic [5:0] order;
        int         n;
        order = '0;
        n = 0;
        if (mask[2]) begin
            order = {order[3:0], 2'd1};
            n++;
        end
        if (mask[1]) begin
            order = {order[3:0], 2'd2};
            n++;
        end
        if (mask[0]) begin
            order = {order[3:0], 2'd3};
            n++;
        end
        return order << (2 * (3 - n));
    endfunction

    // Byte lane merge of an M write
    function automatic void shadowWrite(input logic [31:0] addr, input ahbArbPkg::hSize size,
                                        input logic [31:0] data);
        logic [ahbArbPkg::memIndexBits-1:0] index;
        logic [1:0]                         offset;
        index = addr[ahbArbPkg::memIndexBits+1:2];
        offset = addr[1:0];
        case (size)
            ahbArbPkg::sizeByte: shadow[index][8 * offset +: 8] = data[8 * offset +: 8];
            ahbArbPkg::sizeHalf: shadow[index][16 * offset[1] +: 16] = data[16 * offset[1] +: 16];
            default:             shadow[index] = data;
        endcase
    endfunction

    function automatic stimRow makeRow(input logic [2:0] mask, input logic [31:0] addrT,
                                       input logic [31:0] addrM, input logic [31:0] addrF,
                                       input logic writeM, input ahbArbPkg::hSize sizeM,
                                       input logic [31:0] wdataM, input logic [5:0] order);
        stimRow row;
        row.mask = mask;
        row.addrT = addrT;
        row.addrM = addrM;
        row.addrF = addrF;
        row.writeM = writeM;
        row.sizeM = sizeM;
        row.wdataM = wdataM;
        row.order = order;
        return row;
    endfunction

    // Indices 48..63 so writes and reads collide often
    function automatic stimRow randomRow();
        logic [31:0]     addrBits;
        logic [31:0]     ctrlBits;
        logic [2:0]      mask;
        logic [1:0]      offsetM;
        ahbArbPkg::hSize size;
        addrBits = $urandom;
        ctrlBits = $urandom;
        mask = (ctrlBits[2:0] == 3'b000) ? 3'b111 : ctrlBits[2:0];
        offsetM = ctrlBits[6:5];
        case (ctrlBits[4:3])
            2'd0:    size = ahbArbPkg::sizeByte;
            2'd1:    size = ahbArbPkg::sizeHalf;
            default: size = ahbArbPkg::sizeWord;
        endcase
        if (size == ahbArbPkg::sizeHalf) begin
            offsetM[0] = 1'b0;
        end else if (size == ahbArbPkg::sizeWord) begin
            offsetM = 2'd0;
        end
        return makeRow(mask, {24'd0, 2'b11, addrBits[3:0], 2'b00},
                       {24'd0, 2'b11, addrBits[7:4], offsetM},
                       {24'd0, 2'b11, addrBits[11:8], 2'b00},
                       ctrlBits[7], size, $urandom, expectedOrder(mask));
    endfunction

    task automatic loadTable();
        // Lone masters followed by narrow writes merged into one word
        rows.push_back(makeRow(3'b100, byteAddr(4, 0), byteAddr(0, 0), byteAddr(0, 0),
                               1'b0, ahbArbPkg::sizeWord, 32'h0, 6'b01_00_00));
        rows.push_back(makeRow(3'b010, byteAddr(0, 0), byteAddr(5, 0), byteAddr(0, 0),
                               1'b1, ahbArbPkg::sizeWord, 32'h11223344, 6'b10_00_00));
        rows.push_back(makeRow(3'b001, byteAddr(0, 0), byteAddr(0, 0), byteAddr(5, 0),
                               1'b0, ahbArbPkg::sizeWord, 32'h0, 6'b11_00_00));
        rows.push_back(makeRow(3'b010, byteAddr(0, 0), byteAddr(5, 0), byteAddr(0, 0),
                               1'b0, ahbArbPkg::sizeWord, 32'h0, 6'b10_00_00));
        rows.push_back(makeRow(3'b010, byteAddr(0, 0), byteAddr(6, 1), byteAddr(0, 0),
                               1'b1, ahbArbPkg::sizeByte, 32'h0000ab00, 6'b10_00_00));
        rows.push_back(makeRow(3'b010, byteAddr(0, 0), byteAddr(6, 2), byteAddr(0, 0),
                               1'b1, ahbArbPkg::sizeHalf, 32'hcdef0000, 6'b10_00_00));
        rows.push_back(makeRow(3'b100, byteAddr(6, 0), byteAddr(0, 0), byteAddr(0, 0),
                               1'b0, ahbArbPkg::sizeWord, 32'h0, 6'b01_00_00));
        // Simultaneous masks including TF
        rows.push_back(makeRow(3'b111, byteAddr(7, 0), byteAddr(8, 0), byteAddr(8, 0),
                               1'b1, ahbArbPkg::sizeWord, 32'ha5a55a5a, 6'b01_10_11));
        rows.push_back(makeRow(3'b110, byteAddr(9, 0), byteAddr(6, 0), byteAddr(0, 0),
                               1'b0, ahbArbPkg::sizeWord, 32'h0, 6'b01_10_00));
        rows.push_back(makeRow(3'b101, byteAddr(10, 0), byteAddr(0, 0), byteAddr(11, 0),
                               1'b0, ahbArbPkg::sizeWord, 32'h0, 6'b01_11_00));
        rows.push_back(makeRow(3'b011, byteAddr(0, 0), byteAddr(12, 3), byteAddr(12, 0),
                               1'b1, ahbArbPkg::sizeByte, 32'h77000000, 6'b10_11_00));
        rows.push_back(makeRow(3'b111, byteAddr(3, 0), byteAddr(15, 0), byteAddr(15, 0),
                               1'b1, ahbArbPkg::sizeHalf, 32'h0000beef, 6'b01_10_11));
        rows.push_back(makeRow(3'b101, byteAddr(6, 0), byteAddr(0, 0), byteAddr(6, 0),
                               1'b0, ahbArbPkg::sizeWord, 32'h0, 6'b01_11_00));
        // Top word with three wait states
        rows.push_back(makeRow(3'b010, byteAddr(0, 0), byteAddr(63, 0), byteAddr(0, 0),
                               1'b1, ahbArbPkg::sizeWord, 32'hdeadbeef, 6'b10_00_00));
        rows.push_back(makeRow(3'b001, byteAddr(0, 0), byteAddr(0, 0), byteAddr(63, 0),
                               1'b0, ahbArbPkg::sizeWord, 32'h0, 6'b11_00_00));
        rows.push_back(makeRow(3'b011, byteAddr(0, 0), byteAddr(63, 0), byteAddr(8, 0),
                               1'b0, ahbArbPkg::sizeWord, 32'h0, 6'b10_11_00));
    endtask

    // Drive one row and drop each request after its ready pulse
    task automatic applyRow(input stimRow row);
        int          total;
        int          seen;
        int          cycle;
        logic [2:0]  readies;
        logic [1:0]  gotCode;
        logic [31:0] addr;
        total = $countones(row.mask);
        seen = 0;
        cycle = 0;
        @(posedge clk);
        HRequestT <= row.mask[2];
        HRequestM <= row.mask[1];
        HRequestF <= row.mask[0];
        HAddrT <= row.addrT;
        HAddrM <= row.addrM;
        HAddrF <= row.addrF;
        HWriteM <= row.writeM;
        HSizeM <= row.sizeM;
        HWDataM <= row.wdataM;
        while (seen < total) begin
            @(negedge clk);
            readies = {HReadyT, HReadyM, HReadyF};
            if (readies != 3'b000) begin
                checkValue("readyCount", $countones(readies), 1);
                gotCode = codeOf(readies);
                checkValue("grantOrder", {30'd0, gotCode}, {30'd0, orderAt(row.order, seen)});
                addr = addrOf(row, gotCode);
                // Each address phase starts one cycle after the last answer
                // and its own answer follows 1 + w cycles later
                checkValue("latency", cycle, 1 + waitOf(addr));
                if (gotCode == 2'd2 && row.writeM) begin
                    shadowWrite(addr, row.sizeM, row.wdataM);
                end else begin
                    checkValue("HRData", HRData, shadow[addr[ahbArbPkg::memIndexBits+1:2]]);
                end
                seen++;
                cycle = 0;
            end
            cycle++;
            @(posedge clk);
            if (readies[2]) begin
                HRequestT <= 1'b0;
            end
            if (readies[1]) begin
                HRequestM <= 1'b0;
            end
            if (readies[0]) begin
                HRequestF <= 1'b0;
            end
        end
    endtask

    initial begin
        stimRow row;
        void'($urandom(32'hca38a988));
        reset = 1'b1;
        HRequestT = 1'b0;
        HRequestM = 1'b0;
        HRequestF = 1'b0;
        HAddrT = '0;
        HAddrM = '0;
        HAddrF = '0;
        // Write flag high with no request so HWRITE must be gated by ownership
        HWriteM = 1'b1;
        HSizeM = ahbArbPkg::sizeWord;
        HWDataM = '0;
        for (int w = 0; w < ahbArbPkg::memWords; w++) begin
            shadow[w] = '0;
        end
        loadTable();
        timeoutLimit = (rows.size() + randomRows) * 3 * 5 + 100;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // Quiet bus before any request
        @(negedge clk);
        checkValue("HReadyT", {31'd0, HReadyT}, 32'd0);
        checkValue("HReadyM", {31'd0, HReadyM}, 32'd0);
        checkValue("HReadyF", {31'd0, HReadyF}, 32'd0);
        checkValue("HWRITE", {31'd0, dut.HWRITE}, 32'd0);
        checkValue("HReady", {31'd0, dut.HReady}, 32'd1);
        foreach (rows[i]) begin
            applyRow(rows[i]);
        end
        for (int n = 0; n < randomRows; n++) begin
            row = randomRow();
            applyRow(row);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- bench/ahbArb_assert.sv
`timescale 1ns/1ps

module ahbArbAssert (
    input logic                            clk,
    input logic                            reset,
    input logic                            HRequestT,
    input logic                            HRequestM,
    input logic                            HRequestF,
    input logic                            HWriteM,
    input ahbArbPkg::hSize                 HSizeM,
    input logic [ahbArbPkg::addrWidth-1:0] HAddrM,
    input logic                            HReady,
    input logic                            HSEL,
    input logic                            HWRITE,
    input ahbArbPkg::hSize                 HSIZE,
    input logic [ahbArbPkg::addrWidth-1:0] HADDR,
    input logic                            HReadyT,
    input logic                            HReadyM,
    input logic                            HReadyF
);

    // Only one master can own the data phase
    atMostOneReady: assert property (@(posedge clk) disable iff (reset)
        $onehot0({HReadyT, HReadyM, HReadyF}))
        else $error("More than one master ready in the same cycle");

    // Writes come only from the data cache with its own address
    writeOnlyFromM: assert property (@(posedge clk) disable iff (reset)
        HWRITE |-> (HSEL && HRequestM && HWriteM && HADDR == HAddrM))
        else $error("HWRITE high while M does not own the address phase");

    // T and F always fetch full words
    // Narrow sizes only pass through for the data cache
    wordUnlessM: assert property (@(posedge clk) disable iff (reset)
        (HSIZE != ahbArbPkg::sizeWord) |->
            (HRequestM && HSIZE == HSizeM && HADDR == HAddrM))
        else $error("Narrow HSIZE while M does not own the address phase");

    // A ready pulse goes only to a master still holding its request
    readyNeedsRequest: assert property (@(posedge clk) disable iff (reset)
        (!HReadyT || HRequestT) && (!HReadyM || HRequestM) && (!HReadyF || HRequestF))
        else $error("Ready pulse for a master without a pending request");

    // Presented address frozen by back-pressure
    addrHeldInWait: assert property (@(posedge clk) disable iff (reset)
        !HReady |=> $stable(HADDR))
        else $error("HADDR changed during a wait state");

endmodule

bind ahbArbiterController ahbArbAssert checks (
    .clk       (clk),
    .reset     (reset),
    .HRequestT (HRequestT),
    .HRequestM (HRequestM),
    .HRequestF (HRequestF),
    .HWriteM   (HWriteM),
    .HSizeM    (HSizeM),
    .HAddrM    (HAddrM),
    .HReady    (HReady),
    .HSEL      (HSEL),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HADDR     (HADDR),
    .HReadyT   (HReadyT),
    .HReadyM   (HReadyM),
    .HReadyF   (HReadyF)
);

//--- run.sh
#!/usr/bin/env bash
# Build and run the AHB arbiter testbench with Verilator

buildDir=obj_dir
logFile=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module ahbArbBench \
    -Mdir "$buildDir" -o ahbArbSim \
    -f ahbArb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/ahbArbSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

# The log decides the result
if grep -q "Test failed" "$logFile"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
echo "Simulation passed"
exit 0

//--- src/ahbArbPkg.sv
package ahbArbPkg;

    // Bus widths
    localparam int addrWidth = 32;
    localparam int dataWidth = 32;

    // Word-addressed memory behind the bus
    localparam int memWords = 64;
    localparam int memIndexBits = 6;

    // Wait states per transfer come from HADDR[waitLsb+1:waitLsb]
    localparam int waitLsb = 2;

    // Arbitration sequences for simultaneous requests
    // stSingle handles one owner at a time, the rest walk a fixed order
    typedef enum logic [2:0] {
        stSingle,
        stTmf2,
        stTmf3,
        stMf,
        stTm,
        stTf
    } arbState;

    // AHB transfer sizes, encoded as on HSIZE
    typedef enum logic [2:0] {
        sizeByte = 3'd0,
        sizeHalf = 3'd1,
        sizeWord = 3'd2
    } hSize;

endpackage

//--- src/ahbArbTop.sv
`timescale 1ns/1ps

module ahbArbTop (
    input  logic                            clk,
    input  logic                            reset,
    // Page-table walker, word reads only
    input  logic                            HRequestT,
    input  logic [ahbArbPkg::addrWidth-1:0] HAddrT,
    output logic                            HReadyT,
    // Data cache
    input  logic                            HRequestM,
    input  logic [ahbArbPkg::addrWidth-1:0] HAddrM,
    input  logic                            HWriteM,
    input  ahbArbPkg::hSize                 HSizeM,
    input  logic [ahbArbPkg::dataWidth-1:0] HWDataM,
    output logic                            HReadyM,
    // Instruction cache, word reads only
    input  logic                            HRequestF,
    input  logic [ahbArbPkg::addrWidth-1:0] HAddrF,
    output logic                            HReadyF,
    // Read data shared by all masters
    output logic [ahbArbPkg::dataWidth-1:0] HRData
);

    // Bus between arbiter and slave
    logic                            HSEL;
    logic [ahbArbPkg::addrWidth-1:0] HADDR;
    logic                            HWRITE;
    ahbArbPkg::hSize                 HSIZE;
    logic                            HReady;

    ahbArbiterController arbiter (
        .clk       (clk),
        .reset     (reset),
        .HRequestT (HRequestT),
        .HRequestM (HRequestM),
        .HRequestF (HRequestF),
        .HWriteM   (HWriteM),
        .HSizeM    (HSizeM),
        .HAddrT    (HAddrT),
        .HAddrM    (HAddrM),
        .HAddrF    (HAddrF),
        .HReady    (HReady),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HWRITE    (HWRITE),
        .HSIZE     (HSIZE),
        .HReadyT   (HReadyT),
        .HReadyM   (HReadyM),
        .HReadyF   (HReadyF)
    );

    // Only M writes, so its data goes straight to the slave
    ahbWaitMemory memory (
        .clk    (clk),
        .reset  (reset),
        .HSEL   (HSEL),
        .HADDR  (HADDR),
        .HWRITE (HWRITE),
        .HSIZE  (HSIZE),
        .HWData (HWDataM),
        .HReady (HReady),
        .HRData (HRData)
    );

endmodule

//--- src/ahbArbiterController.sv
`timescale 1ns/1ps

module ahbArbiterController (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            HRequestT,
    input  logic                            HRequestM,
    input  logic                            HRequestF,
    input  logic                            HWriteM,
    input  ahbArbPkg::hSize                 HSizeM,
    input  logic [ahbArbPkg::addrWidth-1:0] HAddrT,
    input  logic [ahbArbPkg::addrWidth-1:0] HAddrM,
    input  logic [ahbArbPkg::addrWidth-1:0] HAddrF,
    input  logic                            HReady,
    output logic                            HSEL,
    output logic [ahbArbPkg::addrWidth-1:0] HADDR,
    output logic                            HWRITE,
    output ahbArbPkg::hSize                 HSIZE,
    output logic                            HReadyT,
    output logic                            HReadyM,
    output logic                            HReadyF
);

    // Address mux select codes
    typedef enum logic [1:0] {
        selT = 2'd0,
        selM = 2'd1,
        selF = 2'd2
    } addrSelCode;

    ahbArbPkg::arbState state;
    ahbArbPkg::arbState nextState;

    // Requests from masters not already in a data phase
    logic reqT;
    logic reqM;
    logic reqF;

    // Owner of the current address phase, one-hot
    logic tSel;
    logic mSel;
    logic fSel;

    // Owner of the previous address phase, now in data phase
    logic prevT;
    logic prevM;
    logic prevF;

    addrSelCode addrSel;

    // A master holds its request until its ready pulse,
    // so its own data phase must not start a second transfer
    assign reqT = HRequestT & ~prevT;
    assign reqM = HRequestM & ~prevM;
    assign reqF = HRequestF & ~prevF;

    // Priority T, then M, then F
    // TMF runs T -> M -> F, TM runs T -> M, TF runs T -> F, MF runs M -> F
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= ahbArbPkg::stSingle;
        end else begin
            state <= nextState;
        end
    end

    // Sequences only advance when the bus accepts an address phase
    always_comb begin
        nextState = state;
        if (HReady) begin
            case (state)
                ahbArbPkg::stSingle: begin
                    if (reqT & reqM & reqF) begin
                        nextState = ahbArbPkg::stTmf2;
                    end else if (reqM & reqF) begin
                        nextState = ahbArbPkg::stMf;
                    end else if (reqT & reqM) begin
                        nextState = ahbArbPkg::stTm;
                    end else if (reqT & reqF) begin
                        // T and F together, M not involved
                        nextState = ahbArbPkg::stTf;
                    end else begin
                        nextState = ahbArbPkg::stSingle;
                    end
                end
                ahbArbPkg::stTmf2: nextState = ahbArbPkg::stTmf3;
                ahbArbPkg::stTmf3: nextState = ahbArbPkg::stSingle;
                ahbArbPkg::stMf:   nextState = ahbArbPkg::stSingle;
                ahbArbPkg::stTm:   nextState = ahbArbPkg::stSingle;
                ahbArbPkg::stTf:   nextState = ahbArbPkg::stSingle;
                default:           nextState = ahbArbPkg::stSingle;
            endcase
        end
    end

    // Current owner
    // In stSingle the highest waiting request wins, later steps are fixed
    assign tSel = (state == ahbArbPkg::stSingle) & reqT;
    assign mSel = ((state == ahbArbPkg::stSingle) & ~reqT & reqM)
                | (state == ahbArbPkg::stTmf2)
                | (state == ahbArbPkg::stTm);
    assign fSel = ((state == ahbArbPkg::stSingle) & ~reqT & ~reqM & reqF)
                | (state == ahbArbPkg::stTmf3)
                | (state == ahbArbPkg::stTf)
                | (state == ahbArbPkg::stMf);

    // Slave select, any master still waiting for the bus
    assign HSEL = tSel | mSel | fSel;

    always_comb begin
        case ({tSel, mSel, fSel})
            3'b100:  addrSel = selT;
            3'b010:  addrSel = selM;
            3'b001:  addrSel = selF;
            default: addrSel = selT;
        endcase
    end

    // Address mux
    always_comb begin
        case (addrSel)
            selT:    HADDR = HAddrT;
            selM:    HADDR = HAddrM;
            selF:    HADDR = HAddrF;
            default: HADDR = HAddrT;
        endcase
    end

    // Only the data cache writes or uses narrow sizes
    assign HWRITE = HWriteM & mSel;
    assign HSIZE  = mSel ? HSizeM : ahbArbPkg::sizeWord;

    // Remember the owner for the data phase, frozen during waits
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            prevT <= 1'b0;
            prevM <= 1'b0;
            prevF <= 1'b0;
        end else if (HReady) begin
            prevT <= tSel;
            prevM <= mSel;
            prevF <= fSel;
        end
    end

    // Ready goes back to whoever owns the data phase
    assign HReadyT = HReady & prevT;
    assign HReadyM = HReady & prevM;
    assign HReadyF = HReady & prevF;

endmodule

//--- src/ahbWaitMemory.sv
`timescale 1ns/1ps

module ahbWaitMemory (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            HSEL,
    input  logic [ahbArbPkg::addrWidth-1:0] HADDR,
    input  logic                            HWRITE,
    input  ahbArbPkg::hSize                 HSIZE,
    input  logic [ahbArbPkg::dataWidth-1:0] HWData,
    output logic                            HReady,
    output logic [ahbArbPkg::dataWidth-1:0] HRData
);

    // Storage, little-endian lanes within each word
    logic [ahbArbPkg::dataWidth-1:0] mem [ahbArbPkg::memWords];

    // Data phase control
    logic       dataPhase;
    logic [1:0] waitCnt;
    logic       writeQ;
    logic       accept;
    logic       writeStrobe;

    // Captured address phase
    logic [ahbArbPkg::memIndexBits-1:0] indexQ;
    logic [1:0]                         offsetQ;
    ahbArbPkg::hSize                    sizeQ;

    logic [ahbArbPkg::dataWidth/8-1:0] laneEnable;

    // Byte lanes touched by a transfer of this size at this offset
    function automatic logic [ahbArbPkg::dataWidth/8-1:0] laneMask(
        input ahbArbPkg::hSize size,
        input logic [1:0]      offset
    );
        logic [ahbArbPkg::dataWidth/8-1:0] mask;
        mask = '0;
        case (size)
            ahbArbPkg::sizeByte: begin
                mask[offset] = 1'b1;
            end
            ahbArbPkg::sizeHalf: begin
                // Halfwords sit on lanes 0-1 or 2-3
                mask[{offset[1], 1'b0}] = 1'b1;
                mask[{offset[1], 1'b1}] = 1'b1;
            end
            ahbArbPkg::sizeWord: begin
                mask = '1;
            end
            default: begin
                mask = '0;
            end
        endcase
        return mask;
    endfunction

    // Low only while wait states remain in a data phase
    assign HReady = ~dataPhase | (waitCnt == 2'd0);

    assign accept      = HSEL & HReady;
    assign writeStrobe = dataPhase & HReady & writeQ;
    assign laneEnable  = laneMask(sizeQ, offsetQ);

    // Wait count loads at acceptance and counts down to zero
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            dataPhase <= 1'b0;
            waitCnt   <= 2'd0;
            writeQ    <= 1'b0;
        end else if (accept) begin
            // New address phase, possibly overlapping the last data cycle
            dataPhase <= 1'b1;
            waitCnt   <= HADDR[ahbArbPkg::waitLsb+1:ahbArbPkg::waitLsb];
            writeQ    <= HWRITE;
        end else if (~HReady) begin
            waitCnt <= waitCnt - 2'd1;
        end else if (dataPhase) begin
            // Final cycle done, bus idle
            dataPhase <= 1'b0;
            writeQ    <= 1'b0;
        end
    end

    // Word index and byte offset of the pending transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            indexQ  <= HADDR[ahbArbPkg::memIndexBits+1:2];
            offsetQ <= HADDR[1:0];
            sizeQ   <= HSIZE;
        end
    end

    // Write data arrives on the final data cycle
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            for (int w = 0; w < ahbArbPkg::memWords; w++) begin
                mem[w] <= '0;
            end
        end else if (writeStrobe) begin
            for (int lane = 0; lane < ahbArbPkg::dataWidth / 8; lane++) begin
                if (laneEnable[lane]) begin
                    mem[indexQ][8*lane +: 8] <= HWData[8*lane +: 8];
                end
            end
        end
    end

    // Full word returned, master picks its lanes
    assign HRData = mem[indexQ];

endmodule
